// ==== bench/mcsr_model.svh ====
/*
  Reference model of the machine CSR state, included inside tb_mcsr.
  Needs mcsr_pkg imported before the include.
  mip is not computed here as the bench sets m_mip from the lines it drives.
*/
`ifndef MCSR_MODEL_SVH
`define MCSR_MODEL_SVH

xlen_t m_mstatus;
xlen_t m_mie;
xlen_t m_mtvec;
xlen_t m_mscratch;
xlen_t m_mepc;
xlen_t m_mcause;
xlen_t m_mtval;
xlen_t m_mip;

task automatic reset_csrs();
    m_mstatus  = '0;
    m_mie      = '0;
    m_mtvec    = '0;
    m_mscratch = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_mtval    = '0;
    m_mip      = '0;
endtask

function automatic xlen_t expected_csr(input csr_addr_t addr);
    case (addr)
        csr_mstatus:   return m_mstatus;
        csr_misa:      return misa_value;
        csr_mie:       return m_mie;
        csr_mtvec:     return m_mtvec;
        csr_mscratch:  return m_mscratch;
        csr_mepc:      return m_mepc;
        csr_mcause:    return m_mcause;
        csr_mtval:     return m_mtval;
        csr_mip:       return m_mip;
        csr_mvendorid: return mvendorid_value;
        csr_marchid:   return marchid_value;
        csr_mimpid:    return mimpid_value;
        csr_mhartid:   return mhartid_value;
        default:       return '0;          // unimplemented
    endcase
endfunction

task automatic store_csr(input csr_addr_t addr, input xlen_t data);
    case (addr)
        csr_mstatus:  m_mstatus  = data;
        csr_mie:      m_mie      = data;
        csr_mtvec:    m_mtvec    = data;
        csr_mscratch: m_mscratch = data;
        csr_mepc:     m_mepc     = data;
        csr_mcause:   m_mcause   = data;
        csr_mtval:    m_mtval    = data;
        default: ;                         // ID regs, misa, mip keep their value
    endcase
endtask

task automatic enter_trap(input xlen_t cause, input xlen_t epc, input xlen_t tval);
    m_mepc                  = epc;
    m_mcause                = cause;
    m_mtval                 = tval;
    m_mstatus[mstatus_mpie] = m_mstatus[mstatus_mie];
    m_mstatus[mstatus_mie]  = 1'b0;
endtask

// exceptions land on the base and vectored interrupts add 4*code
function automatic xlen_t trap_target(input logic is_irq, input xlen_t code);
    xlen_t base;
    base = {m_mtvec[31:2], 2'b00};
    if (is_irq && m_mtvec[0]) begin
        return base + 4 * code;
    end
    return base;
endfunction

`endif

// ==== bench/tb_mcsr.sv ====
/*
  Testbench for mcsr_top: seeded random CSR traffic, exceptions,
  interrupts and the machine timer, all checked against mcsr_model.svh.
  Runs stop at the first mismatch or at any handshake timeout.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_mcsr;
    import mcsr_pkg::*;

    logic        clk;
    logic        rst;
    logic        csr_req;
    logic        csr_write;
    csr_addr_t   csr_addr;
    xlen_t       csr_wdata;
    logic        csr_ack;
    xlen_t       csr_rdata;
    logic        exc_valid;
    xlen_t       exc_code;
    xlen_t       exc_pc;
    xlen_t       exc_tval;
    xlen_t       next_pc;
    logic        trap_hold;
    logic        trap_req;
    logic        trap_ack;
    xlen_t       trap_pc;
    logic        ext_irq;
    logic        soft_irq;
    logic [63:0] mtimecmp;
    logic [63:0] mtime;

    // 13 mapped addresses plus a few holes
    localparam csr_addr_t addr_pool [17] = '{
        csr_mstatus, csr_misa, csr_mie, csr_mtvec, csr_mscratch, csr_mepc,
        csr_mcause, csr_mtval, csr_mip, csr_mvendorid, csr_marchid,
        csr_mimpid, csr_mhartid, 12'h302, 12'h345, 12'h7C0, 12'hB00
    };

    `include "mcsr_model.svh"

    mcsr_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .csr_req   (csr_req),
        .csr_write (csr_write),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .csr_ack   (csr_ack),
        .csr_rdata (csr_rdata),
        .exc_valid (exc_valid),
        .exc_code  (exc_code),
        .exc_pc    (exc_pc),
        .exc_tval  (exc_tval),
        .next_pc   (next_pc),
        .trap_hold (trap_hold),
        .trap_req  (trap_req),
        .trap_ack  (trap_ack),
        .trap_pc   (trap_pc),
        .ext_irq   (ext_irq),
        .soft_irq  (soft_irq),
        .mtimecmp  (mtimecmp),
        .mtime     (mtime)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;             // 8 ns period
    end

    task automatic stop_on_timeout(input string why);
        $display("timeout at %0t ns: %s", $time, why);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check(input xlen_t got, input xlen_t expected, input string what);
        if (got !== expected) begin
            $display("Fail at %0t ns: %s, got %h expected %h", $time, what, got, expected);
            $display("TB FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    // one four-phase access with the old value checked
    task automatic csr_op(input logic wr, input csr_addr_t addr, input xlen_t data);
        xlen_t expected;
        int    n;
        expected  = expected_csr(addr);
        csr_req   = 1'b1;
        csr_write = wr;
        csr_addr  = addr;
        csr_wdata = data;
        n = 0;
        while (!csr_ack) begin
            idle(1);
            n++;
            if (n > 20) stop_on_timeout("csr_ack did not rise");
        end
        check(csr_rdata, expected, $sformatf("rdata of csr %h", addr));
        if (wr) store_csr(addr, data);
        csr_req = 1'b0;
        n = 0;
        while (csr_ack) begin
            idle(1);
            n++;
            if (n > 20) stop_on_timeout("csr_ack did not fall");
        end
    endtask

    // core side of the trap port with ack held back ack_delay cycles
    task automatic take_trap(input int ack_delay, output xlen_t pc);
        int n;
        n = 0;
        while (!trap_req) begin
            idle(1);
            n++;
            if (n > 100) stop_on_timeout("trap_req did not rise");
        end
        exc_valid = 1'b0;                  // core drops it once the redirect is seen
        pc = trap_pc;
        repeat (ack_delay) begin
            idle(1);
            check(trap_req, 1'b1, "trap_req held under back-pressure");
            check(trap_pc, pc, "trap_pc held under back-pressure");
        end
        trap_ack = 1'b1;
        n = 0;
        while (trap_req) begin
            idle(1);
            n++;
            if (n > 20) stop_on_timeout("trap_req did not fall");
        end
        trap_ack = 1'b0;
    endtask

    task automatic quiet_window(input string what);
        repeat (200) begin
            idle(1);
            check(trap_req, 1'b0, what);
        end
    endtask

    initial begin
        xlen_t       pc;
        xlen_t       code;
        logic [63:0] t0;
        void'($urandom(32'ha4b2601d));
        rst       = 1'b0;
        csr_req   = 1'b0;
        csr_write = 1'b0;
        csr_addr  = '0;
        csr_wdata = '0;
        exc_valid = 1'b0;
        exc_code  = '0;
        exc_pc    = '0;
        exc_tval  = '0;
        next_pc   = '0;
        trap_hold = 1'b0;
        trap_ack  = 1'b0;
        ext_irq   = 1'b0;
        soft_irq  = 1'b0;
        mtimecmp  = '1;                    // timer parked far away
        reset_csrs();
        repeat (16) @(posedge clk);
        #1 rst = 1'b1;

        // reset values of every address
        check(trap_req, 1'b0, "trap_req after reset");
        check(csr_ack, 1'b0, "csr_ack after reset");
        foreach (addr_pool[i]) csr_op(1'b0, addr_pool[i], '0);

        // random traffic with quiet lines so mip stays 0
        repeat (300) begin
            csr_op($urandom % 2, addr_pool[$urandom % 17], $urandom);
        end

        // exceptions go to the base even when vectored
        repeat (6) begin
            csr_op(1'b1, csr_mtvec, $urandom | 32'h1);
            csr_op(1'b1, csr_mstatus, $urandom);
            code      = $urandom % 16;
            exc_code  = code;
            exc_pc    = $urandom & ~32'h3;
            exc_tval  = $urandom;
            exc_valid = 1'b1;
            take_trap($urandom % 4, pc);
            check(pc, trap_target(1'b0, code), "exception trap_pc");
            enter_trap(code, exc_pc, exc_tval);
            csr_op(1'b0, csr_mepc, '0);
            csr_op(1'b0, csr_mcause, '0);
            csr_op(1'b0, csr_mtval, '0);
            csr_op(1'b0, csr_mstatus, '0);
        end

        // ext beats soft and then soft alone
        csr_op(1'b1, csr_mtvec, 32'h0000_1001);
        csr_op(1'b1, csr_mie, 32'h888);
        csr_op(1'b1, csr_mstatus, 32'h8);
        next_pc  = $urandom & ~32'h3;
        ext_irq  = 1'b1;
        soft_irq = 1'b1;
        take_trap(0, pc);
        check(pc, trap_target(1'b1, 11), "ext irq trap_pc");
        enter_trap(32'h8000_000b, next_pc, '0);
        csr_op(1'b0, csr_mcause, '0);
        csr_op(1'b0, csr_mepc, '0);
        csr_op(1'b0, csr_mtval, '0);
        ext_irq = 1'b0;
        idle(4);                           // let the synchronizer drain
        csr_op(1'b1, csr_mstatus, 32'h8);
        take_trap(2, pc);
        check(pc, trap_target(1'b1, 3), "soft irq trap_pc");
        enter_trap(32'h8000_0003, next_pc, '0);
        csr_op(1'b0, csr_mcause, '0);
        csr_op(1'b0, csr_mstatus, '0);
        soft_irq = 1'b0;
        idle(4);

        // machine timer
        csr_op(1'b1, csr_mie, 32'h80);
        csr_op(1'b1, csr_mstatus, 32'h8);
        t0       = mtime;
        mtimecmp = mtime + 64'd20;
        take_trap(1, pc);
        check(mtime > t0, 1'b1, "mtime monotonic");
        check(pc, trap_target(1'b1, 7), "timer irq trap_pc");
        enter_trap(32'h8000_0007, next_pc, '0);
        csr_op(1'b0, csr_mcause, '0);
        m_mip = 32'h80;                    // compare still true
        csr_op(1'b0, csr_mip, '0);
        t0       = mtime;
        mtimecmp = '1;
        idle(4);
        check(mtime > t0, 1'b1, "mtime monotonic");
        m_mip = '0;
        csr_op(1'b0, csr_mip, '0);

        // masked by MIE, then by trap_hold, then a late ack
        csr_op(1'b1, csr_mie, 32'h888);
        csr_op(1'b1, csr_mstatus, 32'h0);
        ext_irq  = 1'b1;
        soft_irq = 1'b1;
        quiet_window("trap_req with MIE clear");
        trap_hold = 1'b1;
        csr_op(1'b1, csr_mstatus, 32'h8);
        quiet_window("trap_req with trap_hold high");
        trap_hold = 1'b0;
        take_trap(5 + $urandom % 16, pc);
        check(pc, trap_target(1'b1, 11), "held ext irq trap_pc");
        enter_trap(32'h8000_000b, next_pc, '0);
        csr_op(1'b0, csr_mcause, '0);
        csr_op(1'b0, csr_mstatus, '0);
        ext_irq  = 1'b0;
        soft_irq = 1'b0;
        idle(4);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mcsr.f ====
+incdir+bench
verilog/mcsr_pkg.sv
verilog/csr_bus_if.sv
verilog/trap_commit_if.sv
verilog/machine_timer.sv
verilog/irq_line.sv
verilog/trap_arbiter.sv
verilog/csr_regfile.sv
verilog/mcsr_top.sv
bench/tb_mcsr.sv

// ==== verilog/csr_bus_if.sv ====
/*
  Four-phase CSR access channel between the core pins and the CSR file.
  Host keeps write, addr and wdata stable from req rise until ack falls.
  rdata is only meaningful while ack is high.
*/
`timescale 1ns/1ps
`default_nettype none

interface csr_bus_if;
    import mcsr_pkg::*;

    logic      req;
    logic      ack;
    logic      write;         // 1 = write, 0 = read only
    csr_addr_t addr;
    xlen_t     wdata;
    xlen_t     rdata;         // old value, also on writes

    modport host (
        output req, write, addr, wdata,
        input  ack, rdata
    );

    modport target (
        input  req, write, addr, wdata,
        output ack, rdata
    );

endinterface

`default_nettype wire

// ==== verilog/csr_regfile.sv ====
/*
  Machine CSR storage and bus target.
  Writes to misa, mip and the ID registers are dropped; unknown
  addresses read 0. A trap commit has priority over a bus access on the
  same edge, the access then completes one edge later.
  Reads return the value before the write of the same access.
  MPIE is saved on a trap but never restored (no mret).
*/
`timescale 1ns/1ps
`default_nettype none

module csr_regfile (
    input  wire                             clk,
    input  wire                             rst,
    input  wire  [mcsr_pkg::num_irq-1:0]    pending,
    csr_bus_if.target                       bus,
    trap_commit_if.sink                     commit,
    output logic [mcsr_pkg::num_irq-1:0]    mie_bits,
    output logic                            global_ie,
    output mcsr_pkg::xlen_t                 mtvec
);
    import mcsr_pkg::*;

    xlen_t mstatus;
    xlen_t mie;
    xlen_t mscratch;
    xlen_t mepc;
    xlen_t mcause;
    xlen_t mtval;
    xlen_t mip;
    xlen_t rd_value;
    logic  access;

    // new request, not already acked, not bumped by a commit
    assign access = bus.req && !bus.ack && !commit.valid;

    assign global_ie = mstatus[mstatus_mie];

    // scatter/gather between line index and CSR bit
    always_comb begin
        mip = '0;
        for (int i = 0; i < num_irq; i++) begin
            mip[irq_bit[i]] = pending[i];
            mie_bits[i]     = mie[irq_bit[i]];
        end
    end

    always_comb begin
        case (bus.addr)
            csr_mstatus:   rd_value = mstatus;
            csr_misa:      rd_value = misa_value;
            csr_mie:       rd_value = mie;
            csr_mtvec:     rd_value = mtvec;
            csr_mscratch:  rd_value = mscratch;
            csr_mepc:      rd_value = mepc;
            csr_mcause:    rd_value = mcause;
            csr_mtval:     rd_value = mtval;
            csr_mip:       rd_value = mip;
            csr_mvendorid: rd_value = mvendorid_value;
            csr_marchid:   rd_value = marchid_value;
            csr_mimpid:    rd_value = mimpid_value;
            csr_mhartid:   rd_value = mhartid_value;
            default:       rd_value = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (commit.valid) begin
            mepc                  <= commit.epc;
            mcause                <= commit.cause;
            mtval                 <= commit.tval;
            mstatus[mstatus_mpie] <= mstatus[mstatus_mie];
            mstatus[mstatus_mie]  <= 1'b0;     // handler runs with interrupts off
        end else if (access && bus.write) begin
            case (bus.addr)
                csr_mstatus:  mstatus  <= bus.wdata;
                csr_mie:      mie      <= bus.wdata;
                csr_mtvec:    mtvec    <= bus.wdata;
                csr_mscratch: mscratch <= bus.wdata;
                csr_mepc:     mepc     <= bus.wdata;
                csr_mcause:   mcause   <= bus.wdata;
                csr_mtval:    mtval    <= bus.wdata;
                default: ;                     // read-only or unmapped
            endcase
        end
    end

    // four-phase target side
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bus.ack <= 1'b0;
        end else if (access) begin
            bus.ack <= 1'b1;
        end else if (bus.ack && !bus.req) begin
            bus.ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            bus.rdata <= rd_value;             // stable while ack high
        end
    end

endmodule

`default_nettype wire

// ==== verilog/irq_line.sv ====
/*
  One interrupt line cell: two-flop synchronizer plus the mie mask.
  Raw edges show up on pending two clk edges later.
  The global MIE bit is applied in the arbiter, not here.
*/
`timescale 1ns/1ps
`default_nettype none

module irq_line (
    input  wire  clk,
    input  wire  rst,
    input  wire  raw,          // may be asynchronous to clk
    input  wire  enable,       // matching mie bit
    output logic pending,      // to mip
    output logic fire
);

    logic meta;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            meta    <= 1'b0;
            pending <= 1'b0;
        end else begin
            meta    <= raw;
            pending <= meta;
        end
    end

    assign fire = pending & enable;

endmodule

`default_nettype wire

// ==== verilog/machine_timer.sv ====
/*
  Free-running 64-bit mtime, one tick per clk, zero after reset.
  mtimecmp is an input; there is no memory-mapped register here.
  timer_raw goes high one cycle after mtime >= mtimecmp (unsigned)
  and stays high until mtimecmp is moved above mtime again.
*/
`timescale 1ns/1ps
`default_nettype none

module machine_timer (
    input  wire         clk,
    input  wire         rst,
    input  wire  [63:0] mtimecmp,
    output logic [63:0] mtime,
    output logic        timer_raw
);

    logic cmp_hit;

    assign cmp_hit = (mtime >= mtimecmp);     // unsigned compare

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mtime <= 64'd0;
        end else begin
            mtime <= mtime + 64'd1;            // wraps after 2^64 ticks
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            timer_raw <= 1'b0;
        end else begin
            timer_raw <= cmp_hit;              // level, re-evaluated each cycle
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mcsr_pkg.sv ====
/*
  Shared constants and types for the machine-mode CSR and trap unit.
  RV32 only. ID registers and misa are fixed values, not writable.
  Interrupt lines are indexed 0..2 (soft, timer, ext) and map onto the
  standard mie/mip bit positions, which double as the cause codes.
*/
`default_nettype none

package mcsr_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [11:0]     csr_addr_t;
    typedef logic [xlen-1:0] cause_t;          // bit 31 set for interrupts

    // machine CSR addresses
    localparam csr_addr_t csr_mstatus   = 12'h300;
    localparam csr_addr_t csr_misa      = 12'h301;
    localparam csr_addr_t csr_mie       = 12'h304;
    localparam csr_addr_t csr_mtvec     = 12'h305;
    localparam csr_addr_t csr_mscratch  = 12'h340;
    localparam csr_addr_t csr_mepc      = 12'h341;
    localparam csr_addr_t csr_mcause    = 12'h342;
    localparam csr_addr_t csr_mtval     = 12'h343;
    localparam csr_addr_t csr_mip       = 12'h344;
    localparam csr_addr_t csr_mvendorid = 12'hF11;
    localparam csr_addr_t csr_marchid   = 12'hF12;
    localparam csr_addr_t csr_mimpid    = 12'hF13;
    localparam csr_addr_t csr_mhartid   = 12'hF14;

    // interrupt lines
    localparam int num_irq   = 3;
    localparam int irq_soft  = 0;
    localparam int irq_timer = 1;
    localparam int irq_ext   = 2;

    // mie/mip bit and cause code per line
    localparam int unsigned irq_bit [num_irq] = '{3, 7, 11};

    // mstatus fields
    localparam int mstatus_mie  = 3;
    localparam int mstatus_mpie = 7;

    // read-only identity
    localparam xlen_t misa_value      = 32'h4000_0100;  // RV32I
    localparam xlen_t mvendorid_value = 32'h0000_0000;
    localparam xlen_t marchid_value   = 32'h0000_0000;
    localparam xlen_t mimpid_value    = 32'h0000_0001;
    localparam xlen_t mhartid_value   = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== verilog/mcsr_top.sv ====
/*
  Top level of the machine-mode trap and CSR unit, plain pins only.
  exc_valid must be held by the core until trap_req is seen.
  ext_irq and soft_irq may be asynchronous; they are synchronized here.
  mtimecmp comes from outside and is sampled every cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module mcsr_top (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         csr_req,
    input  wire                         csr_write,
    input  wire  mcsr_pkg::csr_addr_t   csr_addr,
    input  wire  mcsr_pkg::xlen_t       csr_wdata,
    output logic                        csr_ack,
    output mcsr_pkg::xlen_t             csr_rdata,
    input  wire                         exc_valid,
    input  wire  mcsr_pkg::cause_t      exc_code,
    input  wire  mcsr_pkg::xlen_t       exc_pc,
    input  wire  mcsr_pkg::xlen_t       exc_tval,
    input  wire  mcsr_pkg::xlen_t       next_pc,
    input  wire                         trap_hold,
    output logic                        trap_req,
    input  wire                         trap_ack,
    output mcsr_pkg::xlen_t             trap_pc,
    input  wire                         ext_irq,
    input  wire                         soft_irq,
    input  wire  [63:0]                 mtimecmp,
    output logic [63:0]                 mtime
);
    import mcsr_pkg::*;

    logic               timer_raw;
    logic               global_ie;
    xlen_t              mtvec;
    logic [num_irq-1:0] raw_lines;
    logic [num_irq-1:0] pending;
    logic [num_irq-1:0] fire;
    logic [num_irq-1:0] mie_bits;

    csr_bus_if     bus ();
    trap_commit_if commit ();

    // host side of the CSR channel is the pin set
    assign bus.req   = csr_req;
    assign bus.write = csr_write;
    assign bus.addr  = csr_addr;
    assign bus.wdata = csr_wdata;
    assign csr_ack   = bus.ack;
    assign csr_rdata = bus.rdata;

    assign raw_lines[irq_soft]  = soft_irq;
    assign raw_lines[irq_timer] = timer_raw;
    assign raw_lines[irq_ext]   = ext_irq;

    machine_timer u_timer (
        .clk       (clk),
        .rst       (rst),
        .mtimecmp  (mtimecmp),
        .mtime     (mtime),
        .timer_raw (timer_raw)
    );

    for (genvar i = 0; i < num_irq; i++) begin : g_irq
        irq_line u_line (
            .clk     (clk),
            .rst     (rst),
            .raw     (raw_lines[i]),
            .enable  (mie_bits[i]),
            .pending (pending[i]),
            .fire    (fire[i])
        );
    end

    trap_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .fire      (fire),
        .global_ie (global_ie),
        .mtvec     (mtvec),
        .exc_valid (exc_valid),
        .exc_code  (exc_code),
        .exc_pc    (exc_pc),
        .exc_tval  (exc_tval),
        .next_pc   (next_pc),
        .trap_hold (trap_hold),
        .trap_req  (trap_req),
        .trap_pc   (trap_pc),
        .trap_ack  (trap_ack),
        .commit    (commit.source)
    );

    csr_regfile u_csr (
        .clk       (clk),
        .rst       (rst),
        .pending   (pending),
        .bus       (bus.target),
        .commit    (commit.sink),
        .mie_bits  (mie_bits),
        .global_ie (global_ie),
        .mtvec     (mtvec)
    );

endmodule

`default_nettype wire

// ==== verilog/trap_arbiter.sv ====
/*
  Trap priority and redirect to the core.
  Order: exception, then external, software, timer interrupt.
  Interrupts need global_ie. A trap is taken only with trap_req, trap_ack
  and trap_hold all low; the commit strobe fires on that same edge.
  Vectored mode (mtvec[0]) only offsets interrupts, exceptions go to base.
*/
`timescale 1ns/1ps
`default_nettype none

module trap_arbiter (
    input  wire                             clk,
    input  wire                             rst,
    input  wire  [mcsr_pkg::num_irq-1:0]    fire,
    input  wire                             global_ie,
    input  wire  mcsr_pkg::xlen_t           mtvec,
    input  wire                             exc_valid,
    input  wire  mcsr_pkg::cause_t          exc_code,
    input  wire  mcsr_pkg::xlen_t           exc_pc,
    input  wire  mcsr_pkg::xlen_t           exc_tval,
    input  wire  mcsr_pkg::xlen_t           next_pc,
    input  wire                             trap_hold,
    output logic                            trap_req,
    output mcsr_pkg::xlen_t                 trap_pc,
    input  wire                             trap_ack,
    trap_commit_if.source                   commit
);
    import mcsr_pkg::*;

    logic   irq_any;
    logic   take;
    xlen_t  irq_code;
    xlen_t  base;
    cause_t sel_cause;
    xlen_t  sel_epc;
    xlen_t  sel_tval;
    xlen_t  sel_pc;

    assign irq_any = global_ie & (|fire);

    // fixed interrupt ranking
    always_comb begin
        irq_code = '0;
        if (fire[irq_ext]) begin
            irq_code = xlen_t'(irq_bit[irq_ext]);
        end else if (fire[irq_soft]) begin
            irq_code = xlen_t'(irq_bit[irq_soft]);
        end else if (fire[irq_timer]) begin
            irq_code = xlen_t'(irq_bit[irq_timer]);
        end
    end

    assign base = {mtvec[xlen-1:2], 2'b00};

    always_comb begin
        if (exc_valid) begin                   // exceptions always win
            sel_cause = exc_code;
            sel_epc   = exc_pc;
            sel_tval  = exc_tval;
            sel_pc    = base;
        end else begin
            sel_cause = {1'b1, irq_code[xlen-2:0]};
            sel_epc   = next_pc;
            sel_tval  = '0;
            sel_pc    = mtvec[0] ? (base + (irq_code << 2)) : base;
        end
    end

    // idle on both sides and not held off by the core
    assign take = !trap_req && !trap_ack && !trap_hold && (exc_valid || irq_any);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            trap_req <= 1'b0;
        end else if (!trap_req) begin
            trap_req <= take;
        end else if (trap_ack) begin
            trap_req <= 1'b0;                  // wait for ack low before next take
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            trap_pc <= sel_pc;                 // held through back-pressure
        end
    end

    assign commit.valid = take;
    assign commit.cause = sel_cause;
    assign commit.epc   = sel_epc;
    assign commit.tval  = sel_tval;

endmodule

`default_nettype wire

// ==== verilog/trap_commit_if.sv ====
/*
  State update for one taken trap, arbiter to CSR file.
  valid is a single-cycle strobe; the other fields only matter with it.
  For interrupts tval is zero and epc is the next pc.
*/
`timescale 1ns/1ps
`default_nettype none

interface trap_commit_if;
    import mcsr_pkg::*;

    logic   valid;
    cause_t cause;
    xlen_t  epc;
    xlen_t  tval;

    // arbiter side
    modport source (
        output valid, cause, epc, tval
    );

    // CSR file side
    modport sink (
        input valid, cause, epc, tval
    );

endinterface

`default_nettype wire
